//--- bench/platformChecker.sv
`timescale 1ns/10ps
`include "platform_macros.svh"

module platformChecker
    import ioCommandPkg::*;
    import gpioPkg::*;
(
    input  logic      sys_clk,
    input  logic      reset,
    input  ioOpcode_t minorOpcode,
    input  ioAddr_t   commandAddress,
    input  ioData_t   commandData,
    input  destReg_t  commandDestReg,
    input  logic      commandAck,
    input  logic      writebackReq,
    input  destReg_t  writebackDestReg,
    input  ioData_t   writebackData,
    input  logic      writebackAck,
    input  gpioPins_t gpioDIn,
    input  gpioPins_t gpioDOut,
    input  gpioPins_t gpioDOutEn,
    input  logic      systemReady,
    input  ioData_t   expectedRead,
    output int        errorCount
);

    gpioPins_t modelDOut;
    gpioPins_t modelDOutEn;
    ioData_t   pendingData [$];
    destReg_t  pendingTag [$];
    ioData_t   heldData;
    destReg_t  heldTag;
    ioData_t   readValue;
    destReg_t  expTag;
    logic      prevAck;
    logic      prevWbReq;
    logic      resetSeen;
    int        sinceRelease;
    // 0 none, 1 read acked, 2 writebackReq high, 3 waiting for ack to drop
    int        wbPhase;

    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED time=%0t signal=%s actual=0x%0h expected=0x%0h",
                     $time, name, actual, expected);
            errorCount++;
        end
    endtask

    task automatic reportProblem(input string what);
        $display("Error at time %0t: %s", $time, what);
        errorCount++;
    endtask

    // Register index from the window offset or -1 outside the window
    function automatic int regIndex(input ioAddr_t addr);
        int offset;
        offset = int'(addr) - `IOBASEADDR;
        if (offset < 0 || offset >= `TOTALIOBYTES) begin
            return -1;
        end
        return offset % 4;
    endfunction

    initial begin
        errorCount   = 0;
        modelDOut    = '0;
        modelDOutEn  = '0;
        prevAck      = 1'b0;
        prevWbReq    = 1'b0;
        resetSeen    = 1'b0;
        sinceRelease = 0;
        wbPhase      = 0;
    end

    always @(posedge sys_clk) begin
        if (reset) begin
            resetSeen    = 1'b1;
            sinceRelease = 0;
        end else if (resetSeen) begin
            // First edge after release still shows the reset state
            if (sinceRelease == 0) begin
                compareValue("commandAck", commandAck, 0);
                compareValue("writebackReq", writebackReq, 0);
                compareValue("gpioDOut", gpioDOut, 0);
                compareValue("gpioDOutEn", gpioDOutEn, 0);
            end
            compareValue("systemReady", systemReady, sinceRelease > `RESETHOLDCYCLES);
            if (sinceRelease < 1000) begin
                sinceRelease++;
            end
            if (commandAck && !prevAck) begin
                if (!systemReady) begin
                    reportProblem("commandAck rose before systemReady");
                end
                if (wbPhase != 0) begin
                    reportProblem("commandAck rose before the previous writeback finished");
                end
                if (minorOpcode == opWrite) begin
                    if (regIndex(commandAddress) == 0) begin
                        modelDOut = commandData[`GPIOBITWIDTH-1:0];
                    end else if (regIndex(commandAddress) == 1) begin
                        modelDOutEn = commandData[`GPIOBITWIDTH-1:0];
                    end
                end else begin
                    case (regIndex(commandAddress))
                        0:       readValue = ioData_t'(modelDOut);
                        1:       readValue = ioData_t'(modelDOutEn);
                        2:       readValue = ioData_t'(gpioDIn);
                        default: readValue = '0;
                    endcase
                    if (readValue !== expectedRead) begin
                        reportProblem("register model and stimulus table disagree");
                    end
                    pendingData.push_back(readValue);
                    pendingTag.push_back(commandDestReg);
                    wbPhase = 1;
                end
                compareValue("gpioDOut", gpioDOut, modelDOut);
                compareValue("gpioDOutEn", gpioDOutEn, modelDOutEn);
            end
            if (writebackReq && !prevWbReq) begin
                if (commandAck) begin
                    reportProblem("writebackReq rose while commandAck was still high");
                end
                if (pendingData.size() == 0) begin
                    reportProblem("writebackReq rose with no read outstanding");
                end else begin
                    readValue = pendingData.pop_front();
                    expTag    = pendingTag.pop_front();
                    compareValue("writebackData", writebackData, readValue);
                    compareValue("writebackDestReg", writebackDestReg, expTag);
                end
                heldData = writebackData;
                heldTag  = writebackDestReg;
            end else if (writebackReq) begin
                // Payload must not move while the request waits
                compareValue("writebackData", writebackData, heldData);
                compareValue("writebackDestReg", writebackDestReg, heldTag);
            end
            case (wbPhase)
                1: if (writebackReq) wbPhase = 2;
                2: if (!writebackReq) wbPhase = 3;
                3: if (!writebackAck) wbPhase = 0;
                default: ;
            endcase
        end
        prevAck   = commandAck;
        prevWbReq = writebackReq;
    end

endmodule

//--- bench/platformTb.sv
`timescale 1ns/10ps
`include "platform_macros.svh"

module platformTb
    import ioCommandPkg::*;
    import gpioPkg::*;
();

    typedef struct packed {
        ioOpcode_t  opcode;
        ioAddr_t    address;
        ioData_t    writeData;
        destReg_t   destReg;
        gpioPins_t  pins;
        logic [3:0] maxDelay;
        ioData_t    expectedRead;
    } stimEntry_t;

    localparam int tableLen      = 16;
    localparam int timeoutCycles = 16 + `RESETHOLDCYCLES + tableLen * 64;

    // Opcode, address, write data, tag, pins, max ack delay, expected read
    stimEntry_t stimTable [tableLen] = '{
        '{opWrite, 10'd384, 16'h12a5, 4'd0,  8'h00, 4'd0,  16'h0000},
        '{opWrite, 10'd385, 16'h003c, 4'd0,  8'h00, 4'd0,  16'h0000},
        '{opRead,  10'd384, 16'h0000, 4'd3,  8'h00, 4'd0,  16'h00a5},
        '{opRead,  10'd389, 16'h0000, 4'd7,  8'h00, 4'd3,  16'h003c},
        '{opRead,  10'd386, 16'h0000, 4'd9,  8'h5e, 4'd6,  16'h005e},
        '{opWrite, 10'd383, 16'h00ff, 4'd0,  8'h5e, 4'd0,  16'h0000},
        '{opWrite, 10'd512, 16'h00ff, 4'd0,  8'h5e, 4'd0,  16'h0000},
        '{opWrite, 10'd386, 16'h0077, 4'd0,  8'h5e, 4'd0,  16'h0000},
        '{opWrite, 10'd387, 16'h0099, 4'd0,  8'h5e, 4'd0,  16'h0000},
        '{opRead,  10'd387, 16'h0000, 4'd4,  8'h5e, 4'd2,  16'h0000},
        '{opRead,  10'd100, 16'h0000, 4'd12, 8'h5e, 4'd5,  16'h0000},
        '{opRead,  10'd511, 16'h0000, 4'd15, 8'h5e, 4'd1,  16'h0000},
        '{opWrite, 10'd508, 16'hbe81, 4'd0,  8'h5e, 4'd0,  16'h0000},
        '{opRead,  10'd384, 16'h0000, 4'd5,  8'h5e, 4'd12, 16'h0081},
        '{opRead,  10'd390, 16'h0000, 4'd10, 8'hc3, 4'd9,  16'h00c3},
        '{opRead,  10'd385, 16'h0000, 4'd6,  8'hc3, 4'd15, 16'h003c}
    };

    logic      sys_clk;
    logic      reset;
    logic      commandReq;
    ioOpcode_t minorOpcode;
    ioAddr_t   commandAddress;
    ioData_t   commandData;
    destReg_t  commandDestReg;
    logic      commandAck;
    logic      writebackReq;
    destReg_t  writebackDestReg;
    ioData_t   writebackData;
    logic      writebackAck;
    gpioPins_t gpioDIn;
    gpioPins_t gpioDOut;
    gpioPins_t gpioDOutEn;
    logic      systemReady;
    ioData_t   expectedRead;
    int        errorCount;
    int        cycleCount;
    string     waitingFor;
    // Ack delays drawn for reads whose writeback is still to come
    int        ackDelayQueue [$];
    int        writebacksOpen;

    platformTop i_dut (
        .sys_clk(sys_clk), .reset(reset),
        .commandReq(commandReq), .minorOpcode(minorOpcode),
        .commandAddress(commandAddress), .commandData(commandData),
        .commandDestReg(commandDestReg), .commandAck(commandAck),
        .writebackReq(writebackReq), .writebackDestReg(writebackDestReg),
        .writebackData(writebackData), .writebackAck(writebackAck),
        .gpioDIn(gpioDIn), .gpioDOut(gpioDOut), .gpioDOutEn(gpioDOutEn),
        .systemReady(systemReady)
    );

    platformChecker scoreboard (
        .sys_clk(sys_clk), .reset(reset), .minorOpcode(minorOpcode),
        .commandAddress(commandAddress), .commandData(commandData),
        .commandDestReg(commandDestReg), .commandAck(commandAck),
        .writebackReq(writebackReq), .writebackDestReg(writebackDestReg),
        .writebackData(writebackData), .writebackAck(writebackAck),
        .gpioDIn(gpioDIn), .gpioDOut(gpioDOut), .gpioDOutEn(gpioDOutEn),
        .systemReady(systemReady), .expectedRead(expectedRead), .errorCount(errorCount)
    );

    initial begin
        sys_clk = 1'b0;
        forever #4 sys_clk = ~sys_clk;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < timeoutCycles) begin
            @(posedge sys_clk);
            cycleCount++;
        end
        $display("Timeout after %0d cycles while waiting for %s", cycleCount, waitingFor);
        $display("Simulation failed");
        $finish;
    end

    // Processor side of the writeback link
    // Runs beside the command driver so a late ack overlaps the next request
    initial begin
        int delay;
        writebackAck = 1'b0;
        forever begin
            @(negedge sys_clk);
            if (writebackReq === 1'b1 && writebackAck === 1'b0) begin
                delay = 0;
                if (ackDelayQueue.size() != 0) begin
                    delay = ackDelayQueue.pop_front();
                end
                repeat (delay) @(negedge sys_clk);
                writebackAck = 1'b1;
                while (writebackReq !== 1'b0) @(negedge sys_clk);
                writebackAck = 1'b0;
                writebacksOpen--;
            end
        end
    end

    // One four-phase command on the command link
    task automatic runCommand(input stimEntry_t entry);
        int delay;
        @(negedge sys_clk);
        gpioDIn      = entry.pins;
        expectedRead = entry.expectedRead;
        // Give the pin synchronizer time to settle
        repeat (3) @(negedge sys_clk);
        minorOpcode    = entry.opcode;
        commandAddress = entry.address;
        commandData    = entry.writeData;
        commandDestReg = entry.destReg;
        commandReq     = 1'b1;
        waitingFor = "commandAck to rise";
        while (commandAck !== 1'b1) @(negedge sys_clk);
        commandReq = 1'b0;
        if (entry.opcode == opRead) begin
            delay = $urandom % (entry.maxDelay + 1);
            ackDelayQueue.push_back(delay);
            writebacksOpen++;
        end
        waitingFor = "commandAck to fall";
        while (commandAck !== 1'b0) @(negedge sys_clk);
    endtask

    initial begin
        int failedTests;
        int errorsBefore;
        void'($urandom(32'ha6fd));
        failedTests    = 0;
        writebacksOpen = 0;
        reset          = 1'b1;
        commandReq     = 1'b0;
        minorOpcode    = opRead;
        commandAddress = '0;
        commandData    = '0;
        commandDestReg = '0;
        gpioDIn        = '0;
        expectedRead   = '0;
        waitingFor     = "reset";
        repeat (16) @(posedge sys_clk);
        @(negedge sys_clk);
        reset = 1'b0;
        // First request goes out before systemReady on purpose
        for (int i = 0; i < tableLen; i++) begin
            errorsBefore = errorCount;
            runCommand(stimTable[i]);
            if (errorCount != errorsBefore) begin
                failedTests++;
            end
            $display("Test %0d %s address 0x%0h: %s", i,
                     (stimTable[i].opcode == opWrite) ? "write" : "read",
                     stimTable[i].address, (errorCount == errorsBefore) ? "ok" : "FAILED");
        end
        waitingFor = "the last writeback to finish";
        while (writebacksOpen != 0) @(negedge sys_clk);
        repeat (4) @(negedge sys_clk);
        $display("Tests run: %0d, tests failed: %0d, check errors: %0d",
                 tableLen, failedTests, errorCount);
        if (failedTests == 0 && errorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f src.f --top-module platformTb -o platformSim &&
./obj_dir/platformSim | tee /dev/stderr | grep -q "Simulation completed successfully" &&
echo "Run passed" ||
{ echo "Run failed"; exit 1; }

//--- src.f
+incdir+src
src/ioCommandPkg.sv
src/gpioPkg.sv
src/resetSequencer.sv
src/ioManager.sv
src/gpioController.sv
src/platformTop.sv
bench/platformChecker.sv
bench/platformTb.sv

//--- src/gpioController.sv
`timescale 1ns/10ps
`include "platform_macros.svh"

module gpioController
    import ioCommandPkg::*;
    import gpioPkg::*;
(
    input  logic        sys_clk,
    input  logic        reset,

    // Link from the I/O manager
    input  logic        gpioReq,
    input  logic        gpioWriteEn,
    input  gpioRegSel_t gpioRegSel,
    input  ioData_t     gpioDataOut,
    output logic        gpioAck,
    output ioData_t     gpioDataIn,

    // Pins
    input  gpioPins_t   gpioDIn,
    output gpioPins_t   gpioDOut,
    output gpioPins_t   gpioDOutEn
);

    gpioPins_t syncStage1;
    gpioPins_t syncStage2;
    gpioPins_t readValue;
    logic      linkStart;

    // New request with no ack given yet
    assign linkStart = gpioReq && !gpioAck;

    // Two flops on the pin inputs
    always_ff @(posedge sys_clk) begin
        syncStage1 <= gpioDIn;
        syncStage2 <= syncStage1;
    end

    always_comb begin
        case (gpioRegSel)
            regDOut:   readValue = gpioDOut;
            regDOutEn: readValue = gpioDOutEn;
            regDIn:    readValue = syncStage2;
            default:   readValue = '0;
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            gpioAck    <= 1'b0;
            gpioDOut   <= '0;
            gpioDOutEn <= '0;
        end else begin
            gpioAck <= gpioReq;
            // DIn and the reserved index are read only
            if (linkStart && gpioWriteEn) begin
                case (gpioRegSel)
                    regDOut:   gpioDOut   <= gpioDataOut[`GPIOBITWIDTH-1:0];
                    regDOutEn: gpioDOutEn <= gpioDataOut[`GPIOBITWIDTH-1:0];
                    default:   ;
                endcase
            end
        end
    end

    // Held while ack is high
    always_ff @(posedge sys_clk) begin
        if (linkStart) begin
            gpioDataIn <= {{(`DATABITWIDTH - `GPIOBITWIDTH){1'b0}}, readValue};
        end
    end

endmodule

//--- src/gpioPkg.sv
`include "platform_macros.svh"

package gpioPkg;

    // Register index seen on the GPIO link
    typedef enum logic [1:0] {
        regDOut     = 2'd0,
        regDOutEn   = 2'd1,
        regDIn      = 2'd2,
        regReserved = 2'd3
    } gpioRegSel_t;

    // One bit per pin
    typedef logic [`GPIOBITWIDTH-1:0] gpioPins_t;

endpackage

//--- src/ioCommandPkg.sv
`include "platform_macros.svh"

package ioCommandPkg;

    // Minor opcode of an I/O command
    typedef enum logic {
        opRead  = 1'b0,
        opWrite = 1'b1
    } ioOpcode_t;

    // Address on the command port
    typedef logic [`ADDRBITWIDTH-1:0] ioAddr_t;

    // Data word on command, GPIO and writeback links
    typedef logic [`DATABITWIDTH-1:0] ioData_t;

    // Register file tag carried with a read and echoed on writeback
    typedef logic [`DESTREGBITWIDTH-1:0] destReg_t;

endpackage

//--- src/ioManager.sv
`timescale 1ns/10ps
`include "platform_macros.svh"

module ioManager
    import ioCommandPkg::*;
    import gpioPkg::*;
(
    input  logic        sys_clk,
    input  logic        reset,
    input  logic        systemReady,

    // Command link from the processor
    input  logic        commandReq,
    input  ioOpcode_t   minorOpcode,
    input  ioAddr_t     commandAddress,
    input  ioData_t     commandData,
    input  destReg_t    commandDestReg,
    output logic        commandAck,

    // GPIO link
    output logic        gpioReq,
    output logic        gpioWriteEn,
    output gpioRegSel_t gpioRegSel,
    output ioData_t     gpioDataOut,
    input  logic        gpioAck,
    input  ioData_t     gpioDataIn,

    // Writeback link to the processor
    output logic        writebackReq,
    output destReg_t    writebackDestReg,
    output ioData_t     writebackData,
    input  logic        writebackAck
);

    localparam int windowLow  = `IOBASEADDR;
    localparam int windowHigh = `IOBASEADDR + `TOTALIOBYTES;

    typedef enum logic [2:0] {
        stIdle,
        stGpioReq,
        stGpioDrop,
        stCmdAck,
        stWbIssue,
        stWbReq,
        stWbDrop
    } ioState_t;

    ioState_t  state;
    ioOpcode_t opcodeReg;
    ioAddr_t   addrOffset;
    logic      inRange;
    logic      accept;

    // Window decode on the live command address
    assign inRange    = (int'(commandAddress) >= windowLow) &&
                        (int'(commandAddress) < windowHigh);
    assign addrOffset = commandAddress - ioAddr_t'(windowLow);

    // One command at a time and only once the platform is up
    assign accept = (state == stIdle) && commandReq && systemReady;

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            state        <= stIdle;
            commandAck   <= 1'b0;
            gpioReq      <= 1'b0;
            writebackReq <= 1'b0;
        end else begin
            case (state)
                stIdle: begin
                    if (accept) begin
                        if (inRange) begin
                            gpioReq <= 1'b1;
                            state   <= stGpioReq;
                        end else begin
                            // Answer without touching GPIO when outside the window
                            commandAck <= 1'b1;
                            state      <= stCmdAck;
                        end
                    end
                end
                stGpioReq: begin
                    if (gpioAck) begin
                        gpioReq <= 1'b0;
                        state   <= stGpioDrop;
                    end
                end
                stGpioDrop: begin
                    if (!gpioAck) begin
                        commandAck <= 1'b1;
                        state      <= stCmdAck;
                    end
                end
                stCmdAck: begin
                    if (!commandReq) begin
                        commandAck <= 1'b0;
                        if (opcodeReg == opRead) begin
                            state <= stWbIssue;
                        end else begin
                            state <= stIdle;
                        end
                    end
                end
                stWbIssue: begin
                    writebackReq <= 1'b1;
                    state        <= stWbReq;
                end
                stWbReq: begin
                    if (writebackAck) begin
                        writebackReq <= 1'b0;
                        state        <= stWbDrop;
                    end
                end
                stWbDrop: begin
                    // Wait for the processor to close the handshake
                    if (!writebackAck) begin
                        state <= stIdle;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // Command payload and read result
    always_ff @(posedge sys_clk) begin
        if (accept) begin
            opcodeReg        <= minorOpcode;
            gpioWriteEn      <= (minorOpcode == opWrite);
            gpioRegSel       <= gpioRegSel_t'(addrOffset[1:0]);
            gpioDataOut      <= commandData;
            writebackDestReg <= commandDestReg;
            // Reads outside the window return zero
            writebackData    <= '0;
        end else if ((state == stGpioReq) && gpioAck) begin
            writebackData <= gpioDataIn;
        end
    end

endmodule

//--- src/platformTop.sv
`timescale 1ns/10ps
`include "platform_macros.svh"

module platformTop
    import ioCommandPkg::*;
    import gpioPkg::*;
(
    input  logic      sys_clk,
    input  logic      reset,

    // Command link
    input  logic      commandReq,
    input  ioOpcode_t minorOpcode,
    input  ioAddr_t   commandAddress,
    input  ioData_t   commandData,
    input  destReg_t  commandDestReg,
    output logic      commandAck,

    // Writeback link
    output logic      writebackReq,
    output destReg_t  writebackDestReg,
    output ioData_t   writebackData,
    input  logic      writebackAck,

    // GPIO pins
    input  gpioPins_t gpioDIn,
    output gpioPins_t gpioDOut,
    output gpioPins_t gpioDOutEn,

    output logic      systemReady
);

    logic        platformReset;

    logic        gpioReq;
    logic        gpioWriteEn;
    gpioRegSel_t gpioRegSel;
    ioData_t     gpioDataOut;
    logic        gpioAck;
    ioData_t     gpioDataIn;

    resetSequencer resetSystem (
        .sys_clk      (sys_clk),
        .reset        (reset),
        .platformReset(platformReset),
        .systemReady  (systemReady)
    );

    ioManager ioInterface (
        .sys_clk         (sys_clk),
        .reset           (platformReset),
        .systemReady     (systemReady),
        .commandReq      (commandReq),
        .minorOpcode     (minorOpcode),
        .commandAddress  (commandAddress),
        .commandData     (commandData),
        .commandDestReg  (commandDestReg),
        .commandAck      (commandAck),
        .gpioReq         (gpioReq),
        .gpioWriteEn     (gpioWriteEn),
        .gpioRegSel      (gpioRegSel),
        .gpioDataOut     (gpioDataOut),
        .gpioAck         (gpioAck),
        .gpioDataIn      (gpioDataIn),
        .writebackReq    (writebackReq),
        .writebackDestReg(writebackDestReg),
        .writebackData   (writebackData),
        .writebackAck    (writebackAck)
    );

    gpioController gpioInterface (
        .sys_clk    (sys_clk),
        .reset      (platformReset),
        .gpioReq    (gpioReq),
        .gpioWriteEn(gpioWriteEn),
        .gpioRegSel (gpioRegSel),
        .gpioDataOut(gpioDataOut),
        .gpioAck    (gpioAck),
        .gpioDataIn (gpioDataIn),
        .gpioDIn    (gpioDIn),
        .gpioDOut   (gpioDOut),
        .gpioDOutEn (gpioDOutEn)
    );

endmodule

//--- src/platform_macros.svh
`ifndef PLATFORM_MACROS_SVH
`define PLATFORM_MACROS_SVH

// Datapath widths
`define DATABITWIDTH 16
`define ADDRBITWIDTH 10
`define DESTREGBITWIDTH 4

// Number of GPIO pins
`define GPIOBITWIDTH 8

// Memory-mapped I/O window from 384 up to 511
`define IOBASEADDR 384
`define TOTALIOBYTES 128

// Internal reset stretch after the external reset falls
`define RESETHOLDCYCLES 8

`endif

//--- src/resetSequencer.sv
`timescale 1ns/10ps
`include "platform_macros.svh"

module resetSequencer (
    input  logic sys_clk,
    input  logic reset,
    output logic platformReset,
    output logic systemReady
);

    localparam int countWidth = $clog2(`RESETHOLDCYCLES + 1);

    logic [countWidth-1:0] holdCount;
    logic [countWidth-1:0] holdCountNext;

    // Count down to zero and stay there
    always_comb begin
        if (holdCount != '0) begin
            holdCountNext = holdCount - 1'b1;
        end else begin
            holdCountNext = holdCount;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            holdCount     <= countWidth'(`RESETHOLDCYCLES);
            platformReset <= 1'b1;
            systemReady   <= 1'b0;
        end else begin
            holdCount     <= holdCountNext;
            // Released on the edge where the count lands on zero
            platformReset <= (holdCountNext != '0);
            // Ready follows one cycle behind the release
            systemReady   <= ~platformReset;
        end
    end

endmodule
